// ==== cpu16.f ====
rtl/cpu16_pkg.sv
rtl/dual_port_ram.sv
rtl/program_counter.sv
rtl/regfile.sv
rtl/alu.sv
rtl/control_decoder.sv
rtl/cpu16_top.sv
bench/cpu16_tb.sv

// ==== Makefile ====
# cpu16 simulation with Verilator
TOP = cpu16_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f cpu16.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) > run.log 2>&1 || true
	@cat run.log
	@if grep -q "Done: errors found" run.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" run.log || { echo "simulation did not complete"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ) run.log

// ==== bench/cpu16_tb.sv ====
`timescale 1ns/1ps

module cpu16_tb;
	import cpu16_pkg::*;

	localparam int num_progs = 3;
	localparam int body_len = 60;    // random words after the preamble
	localparam int data_base = 128;
	localparam logic [data_w-1:0] loop_word = {op_bcond, cond_uc, 8'h00};   // b uc .+0
	// per program: port b load, 80 instrs of 4 cycles, slack for reset and readback
	localparam int watchdog_ns = num_progs * (mem_depth + 80 * 4 + 300) * 4;

	logic              clk;
	logic              reset;
	logic [data_w-1:0] ext_addr;
	logic [data_w-1:0] ext_wdata;
	logic              ext_we;
	logic [data_w-1:0] ext_rdata;
	logic [data_w-1:0] out;
	logic              retire;

	logic [data_w-1:0] prog [mem_depth];    // full image for port b
	logic [data_w-1:0] mmem [mem_depth];    // model memory
	logic [data_w-1:0] mregs [num_regs];
	logic [data_w-1:0] exp_out [256];       // per executed instruction
	int                exp_cyc [256];
	int                n_exp;               // instructions before the self-loop
	int                cycle = 0;
	int                errors = 0;
	int                checks = 0;
	int unsigned       seed_ret;

	cpu16_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.ext_addr  (ext_addr),
		.ext_wdata (ext_wdata),
		.ext_we    (ext_we),
		.ext_rdata (ext_rdata),
		.out       (out),
		.retire    (retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		#(watchdog_ns);
		$display("timeout: run did not finish within %0d ns", watchdog_ns);
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [data_w-1:0] sign_extend(input logic [7:0] v);
		return {{(data_w-8){v[7]}}, v};
	endfunction

	function automatic logic cond_holds(input logic [3:0] cc, input logic [flag_w-1:0] f);
		case (cc)
			cond_eq: return f[flag_z];
			cond_ne: return !f[flag_z];
			cond_cs: return f[flag_c];
			cond_cc: return !f[flag_c];
			cond_lo: return f[flag_l];
			cond_hs: return !f[flag_l];
			cond_mi: return f[flag_n];
			cond_uc: return 1'b1;
			default: return 1'b0;   // unused codes never hold
		endcase
	endfunction

	task automatic compare(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic build_program(input int p);
		int         pos;
		logic [3:0] op;
		logic [3:0] rd;
		logic [7:0] lit;
		logic       after_jump;   // next word may be skipped by a taken jcond
		for (int k = 0; k < mem_depth; k++)
			prog[k] = 16'(k * 16'h9e37) ^ 16'(p * 16'h1111) ^ 16'h5a5a;   // odd multiplier
		prog[0] = {op_movi, 4'd15, 8'(data_base)};   // r15 points at data
		pos = 1;
		after_jump = 1'b0;
		while (pos <= body_len) begin
			op = 4'($urandom % 16);
			rd = 4'($urandom % 15);   // r15 stays the data pointer
			lit = 8'($urandom);
			if (op == op_jcond && (pos == body_len || after_jump))
				op = op_nop;   // pair would not fit or its movi could be skipped
			after_jump = 1'b0;
			case (op)
				op_addi, op_subi, op_movi: prog[pos] = {op, rd, lit};
				op_load, op_stor: prog[pos] = {op, rd, 8'h0f};
				op_bcond: prog[pos] = {op, lit[3:0], 8'(1 + $urandom % 3)};
				op_jcond: begin
					prog[pos] = {op_movi, 4'd13, 8'(pos + 3)};   // taken jump skips one word
					pos++;
					prog[pos] = {op, lit[3:0], 8'h0d};
					after_jump = 1'b1;
				end
				default: prog[pos] = {op, rd, 4'h0, lit[3:0]};
			endcase
			pos++;
		end
		// forward branch landing on a jcond would skip its movi, aim at the movi instead
		for (int k = 1; k <= body_len; k++)
			if (prog[k][15:12] == op_bcond && prog[k + prog[k][7:0]][15:12] == op_jcond)
				prog[k][7:0] = prog[k][7:0] - 8'd1;
		for (int r = 0; r < 15; r++) begin
			prog[pos] = {op_movi, 4'd15, 8'(200 + r)};
			prog[pos + 1] = {op_stor, 4'(r), 8'h0f};
			pos += 2;
		end
		prog[pos] = loop_word;
	endtask

	task automatic run_model();
		logic [data_w-1:0] pc;
		logic [data_w-1:0] nxt;
		logic [data_w-1:0] w;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] res;
		logic [data_w:0]   wide;
		logic [flag_w-1:0] fl;
		logic [3:0]        op;
		logic              cin;
		int                sres;
		pc = '0;
		fl = '0;
		n_exp = 0;
		for (int k = 0; k < num_regs; k++)
			mregs[k] = '0;
		for (int k = 0; k < mem_depth; k++)
			mmem[k] = prog[k];
		while (mmem[pc[mem_aw-1:0]] != loop_word && n_exp < 200) begin
			w = mmem[pc[mem_aw-1:0]];
			op = w[15:12];
			a = mregs[w[11:8]];   // rdest, or the cond field on branches
			if (op == op_addi || op == op_subi)
				b = sign_extend(w[7:0]);
			else if (op == op_movi)
				b = {8'h00, w[7:0]};
			else
				b = mregs[w[3:0]];
			cin = (op == op_addc) && fl[flag_c];
			res = a;   // load, stor, branches and nop show rdest
			nxt = pc + 1;
			case (op)
				op_add, op_addi, op_addc: begin
					wide = a + b + cin;
					res = wide[data_w-1:0];
					sres = $signed(a) + $signed(b) + int'(cin);
					// n c f z l
					fl = {res[15], wide[data_w], (sres > 32767 || sres < -32768), (res == 0), 1'b0};
				end
				op_sub, op_subi, op_cmp: begin
					res = a - b;
					sres = $signed(a) - $signed(b);
					fl = {res[15], (a < b), (sres > 32767 || sres < -32768), (res == 0), (a < b)};
				end
				op_and: res = a & b;
				op_or: res = a | b;
				op_xor: res = a ^ b;
				op_mov, op_movi: res = b;
				op_load: mregs[w[11:8]] = mmem[b[mem_aw-1:0]];
				op_stor: mmem[b[mem_aw-1:0]] = a;
				op_bcond:
					if (cond_holds(w[11:8], fl))
						nxt = pc + sign_extend(w[7:0]);
				op_jcond:
					if (cond_holds(w[11:8], fl))
						nxt = b;
				default: begin
				end
			endcase
			if (op <= op_movi || op == op_addc)
				mregs[w[11:8]] = res;
			exp_out[n_exp] = res;
			exp_cyc[n_exp] = (op == op_load) ? 4 : 3;   // extra write-back cycle
			n_exp++;
			pc = nxt;
		end
		exp_out[n_exp] = mregs[cond_uc];   // self-loop shows r14
		exp_cyc[n_exp] = 3;
	endtask

	initial begin
		int   last;
		int   idx;
		logic done;
		logic at_loop;
		seed_ret = $urandom(32'h1361);
		reset = 1'b0;
		ext_addr = '0;
		ext_wdata = '0;
		ext_we = 1'b0;
		for (int p = 0; p < num_progs; p++) begin
			build_program(p);
			run_model();
			// reset held through the load, then 8 more cycles
			@(posedge clk);
			reset <= 1'b0;
			for (int k = 0; k < mem_depth; k++) begin
				ext_addr <= 16'(k);
				ext_wdata <= prog[k];
				ext_we <= 1'b1;
				@(posedge clk);
			end
			ext_we <= 1'b0;
			repeat (8) begin
				@(negedge clk);
				compare("retire", 16'(retire), 16'h0);
				@(posedge clk);
			end
			reset <= 1'b1;
			@(negedge clk);
			last = cycle - 1;   // fetch of instruction 0 is this cycle
			idx = 0;
			done = 1'b0;
			while (!done) begin
				if (retire) begin
					compare("retire gap", 16'(cycle - last), 16'(exp_cyc[idx]));
					compare("out", out, exp_out[idx]);
					at_loop = (u_dut.u_ctrl.ir == loop_word);
					if (at_loop || idx == n_exp) begin
						if (!at_loop || idx != n_exp) begin
							errors++;
							$display("control flow: retire %0d at_loop=%0b, model loops at %0d",
								idx, at_loop, n_exp);
						end
						done = 1'b1;
					end
					last = cycle;
					idx++;
				end
				if (!done)
					@(negedge clk);
			end
			// data region readback, address one cycle ahead of the data
			for (int i = 0; i <= mem_depth - data_base; i++) begin
				@(posedge clk);
				if (i < mem_depth - data_base)
					ext_addr <= 16'(data_base + i);
				@(negedge clk);
				if (i > 0)
					compare($sformatf("mem[%0d]", data_base + i - 1), ext_rdata,
						mmem[data_base + i - 1]);
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== rtl/cpu16_top.sv ====
`timescale 1ns/1ps

module cpu16_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [cpu16_pkg::data_w-1:0] ext_addr,    // ram port b, loader side
	input  logic [cpu16_pkg::data_w-1:0] ext_wdata,
	input  logic                         ext_we,
	output logic [cpu16_pkg::data_w-1:0] ext_rdata,   // one cycle after ext_addr
	output logic [cpu16_pkg::data_w-1:0] out,
	output logic                         retire
);
	import cpu16_pkg::*;

	// control steering
	logic                pc_en;
	logic [1:0]          pc_sel;
	logic                addr_sel;
	logic                imm_sel;
	logic                wb_sel;
	logic                mem_we;
	logic [num_regs-1:0] reg_en;
	logic [op_w-1:0]     op;
	logic [reg_aw-1:0]   rdest;
	logic [reg_aw-1:0]   rsrc;
	logic [data_w-1:0]   imm;
	logic [7:0]          disp;

	// datapath
	logic [data_w-1:0]   pc;
	logic [data_w-1:0]   mem_addr_a;
	logic [data_w-1:0]   q_a;
	logic [data_w-1:0]   rdata_a;
	logic [data_w-1:0]   rdata_b;
	logic [data_w-1:0]   alu_b;
	logic [data_w-1:0]   alu_result;
	logic [data_w-1:0]   reg_wdata;
	logic [flag_w-1:0]   flags;
	logic [flag_w-1:0]   flags_next;

	// three datapath muxes
	assign mem_addr_a = addr_sel ? rdata_b : pc;     // fetch or load/store
	assign alu_b = imm_sel ? imm : rdata_b;
	assign reg_wdata = wb_sel ? q_a : alu_result;   // memory only for load wb

	assign out = alu_result;

	dual_port_ram u_ram (
		.clk    (clk),
		.addr_a (mem_addr_a),
		.data_a (rdata_a),   // store data from rdest
		.we_a   (mem_we),
		.q_a    (q_a),
		.addr_b (ext_addr),
		.data_b (ext_wdata),
		.we_b   (ext_we),
		.q_b    (ext_rdata)
	);

	program_counter u_pc (
		.clk    (clk),
		.reset  (reset),
		.en     (pc_en),
		.sel    (pc_sel),
		.disp   (disp),
		.target (rdata_b),
		.pc     (pc)
	);

	regfile u_regs (
		.clk     (clk),
		.reset   (reset),
		.wdata   (reg_wdata),
		.reg_en  (reg_en),
		.raddr_a (rdest),
		.raddr_b (rsrc),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	alu u_alu (
		.a          (rdata_a),
		.b          (alu_b),
		.op         (op),
		.flags      (flags),
		.result     (alu_result),
		.flags_next (flags_next)
	);

	control_decoder u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.instr      (q_a),
		.flags_next (flags_next),
		.flags      (flags),
		.pc_en      (pc_en),
		.pc_sel     (pc_sel),
		.addr_sel   (addr_sel),
		.imm_sel    (imm_sel),
		.wb_sel     (wb_sel),
		.mem_we     (mem_we),
		.retire     (retire),
		.reg_en     (reg_en),
		.op         (op),
		.rdest      (rdest),
		.rsrc       (rsrc),
		.imm        (imm),
		.disp       (disp)
	);

endmodule

// ==== rtl/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [cpu16_pkg::data_w-1:0]   instr,        // q_a from ram
	input  logic [cpu16_pkg::flag_w-1:0]   flags_next,
	output logic [cpu16_pkg::flag_w-1:0]   flags,
	output logic                           pc_en,
	output logic [1:0]                     pc_sel,
	output logic                           addr_sel,     // 0 pc, 1 rsrc
	output logic                           imm_sel,
	output logic                           wb_sel,       // 0 alu, 1 memory
	output logic                           mem_we,
	output logic                           retire,
	output logic [cpu16_pkg::num_regs-1:0] reg_en,
	output logic [cpu16_pkg::op_w-1:0]     op,
	output logic [cpu16_pkg::reg_aw-1:0]   rdest,
	output logic [cpu16_pkg::reg_aw-1:0]   rsrc,
	output logic [cpu16_pkg::data_w-1:0]   imm,
	output logic [7:0]                     disp
);
	import cpu16_pkg::*;

	logic [1:0]        state;
	logic [1:0]        state_nx;
	logic [data_w-1:0] ir;
	logic              executing;
	logic              cond_ok;
	logic              writes_reg;   // alu op with register result
	logic              mem_op;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_fetch;
			ir <= {op_nop, {(data_w-op_w){1'b0}}};   // keeps out defined before first decode
			flags <= '0;
		end else begin
			state <= state_nx;
			if (state == st_decode)
				ir <= instr;   // ram data valid one cycle after fetch
			if (retire)
				flags <= flags_next;
		end
	end

	always_comb begin
		case (state)
			st_fetch: state_nx = st_decode;
			st_decode: state_nx = st_exec;
			st_exec: state_nx = (op == op_load) ? st_wb : st_fetch;
			default: state_nx = st_fetch;
		endcase
	end

	// fixed field split
	assign op = ir[15:12];
	assign rdest = ir[11:8];   // doubles as cond code
	assign rsrc = ir[3:0];
	assign disp = ir[7:0];
	assign imm = (op == op_movi) ? {8'h00, ir[7:0]} : {{8{ir[7]}}, ir[7:0]};

	// condition on the stored flags
	always_comb begin
		case (rdest)
			cond_eq: cond_ok = flags[flag_z];
			cond_ne: cond_ok = !flags[flag_z];
			cond_cs: cond_ok = flags[flag_c];
			cond_cc: cond_ok = !flags[flag_c];
			cond_lo: cond_ok = flags[flag_l];
			cond_hs: cond_ok = !flags[flag_l];
			cond_mi: cond_ok = flags[flag_n];
			cond_uc: cond_ok = 1'b1;
			default: cond_ok = 1'b0;   // never
		endcase
	end

	assign executing = (state == st_exec);
	assign mem_op = (op == op_load) || (op == op_stor);
	assign imm_sel = (op == op_addi) || (op == op_subi) || (op == op_movi);
	assign writes_reg = !(op inside {op_cmp, op_load, op_stor, op_bcond, op_jcond, op_nop});

	// load retires in write-back instead of exec
	assign retire = (executing && (op != op_load)) || (state == st_wb);
	assign pc_en = retire;

	always_comb begin
		if (op == op_bcond && cond_ok)
			pc_sel = pcsel_branch;
		else if (op == op_jcond && cond_ok)
			pc_sel = pcsel_jump;
		else
			pc_sel = pcsel_inc;   // also failed conditions
	end

	assign addr_sel = (executing && mem_op) || (state == st_wb);
	assign mem_we = executing && (op == op_stor);
	assign wb_sel = (state == st_wb);

	// one-hot write on rdest
	assign reg_en = ((executing && writes_reg) || (state == st_wb))
		? ({{(num_regs-1){1'b0}}, 1'b1} << rdest) : '0;

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [cpu16_pkg::data_w-1:0] a,            // rdest value
	input  logic [cpu16_pkg::data_w-1:0] b,            // rsrc value or imm
	input  logic [cpu16_pkg::op_w-1:0]   op,
	input  logic [cpu16_pkg::flag_w-1:0] flags,        // stored flags
	output logic [cpu16_pkg::data_w-1:0] result,
	output logic [cpu16_pkg::flag_w-1:0] flags_next
);
	import cpu16_pkg::*;

	logic              cin;
	logic [data_w:0]   sum;    // msb is carry out
	logic [data_w:0]   diff;   // msb is borrow
	logic              add_ovf;
	logic              sub_ovf;

	assign cin = (op == op_addc) ? flags[flag_c] : 1'b0;   // only addc chains
	assign sum = {1'b0, a} + {1'b0, b} + {{data_w{1'b0}}, cin};
	assign diff = {1'b0, a} - {1'b0, b};

	// same signs in, different sign out
	assign add_ovf = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
	// a - b overflows only when signs differ
	assign sub_ovf = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

	always_comb begin
		case (op)
			op_add, op_addi, op_addc: result = sum[data_w-1:0];
			op_sub, op_subi, op_cmp: result = diff[data_w-1:0];   // cmp shows difference
			op_and: result = a & b;
			op_or: result = a | b;
			op_xor: result = a ^ b;
			op_mov, op_movi: result = b;
			default: result = a;   // load, stor, branches, nop
		endcase
	end

	always_comb begin
		flags_next = flags;   // hold for non-arith ops
		case (op)
			op_add, op_addi, op_addc: begin
				flags_next[flag_n] = result[data_w-1];
				flags_next[flag_c] = sum[data_w];
				flags_next[flag_f] = add_ovf;
				flags_next[flag_z] = (result == '0);
				flags_next[flag_l] = 1'b0;   // no compare on adds
			end
			op_sub, op_subi, op_cmp: begin
				flags_next[flag_n] = result[data_w-1];
				flags_next[flag_c] = diff[data_w];
				flags_next[flag_f] = sub_ovf;
				flags_next[flag_z] = (result == '0);
				// borrow out is exactly a < b unsigned
				flags_next[flag_l] = diff[data_w];
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [cpu16_pkg::data_w-1:0]   wdata,
	input  logic [cpu16_pkg::num_regs-1:0] reg_en,   // one-hot, all zero for no write
	input  logic [cpu16_pkg::reg_aw-1:0]   raddr_a,
	input  logic [cpu16_pkg::reg_aw-1:0]   raddr_b,
	output logic [cpu16_pkg::data_w-1:0]   rdata_a,
	output logic [cpu16_pkg::data_w-1:0]   rdata_b
);
	import cpu16_pkg::*;

	logic [data_w-1:0] regs [num_regs];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_regs; i++) begin
				if (reg_en[i])
					regs[i] <= wdata;   // new value seen after the edge
			end
		end
	end

	// async reads
	// port a is rdest, also store data
	assign rdata_a = regs[raddr_a];
	// port b is rsrc, also mem address and jump target
	assign rdata_b = regs[raddr_b];

endmodule

// ==== rtl/program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         en,      // one pulse per retired instruction
	input  logic [1:0]                   sel,
	input  logic [7:0]                   disp,    // raw branch displacement
	input  logic [cpu16_pkg::data_w-1:0] target,  // jump address from rsrc
	output logic [cpu16_pkg::data_w-1:0] pc
);
	import cpu16_pkg::*;

	logic [data_w-1:0] disp_ext;

	// relative to the branch itself, so disp 0 spins in place
	assign disp_ext = {{(data_w-8){disp[7]}}, disp};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;   // first fetch from word 0
		end else if (en) begin
			case (sel)
				pcsel_branch: pc <= pc + disp_ext;
				pcsel_jump: pc <= target;
				default: pc <= pc + 1'b1;   // pcsel_inc and untaken branches
			endcase
		end
	end

endmodule

// ==== rtl/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram (
	input  logic                         clk,
	input  logic [cpu16_pkg::data_w-1:0] addr_a,
	input  logic [cpu16_pkg::data_w-1:0] data_a,
	input  logic                         we_a,
	output logic [cpu16_pkg::data_w-1:0] q_a,
	input  logic [cpu16_pkg::data_w-1:0] addr_b,
	input  logic [cpu16_pkg::data_w-1:0] data_b,
	input  logic                         we_b,
	output logic [cpu16_pkg::data_w-1:0] q_b
);
	import cpu16_pkg::*;

	logic [data_w-1:0] mem [mem_depth];
	logic [mem_aw-1:0] wa;   // decoded part of addr_a
	logic [mem_aw-1:0] wb;

	assign wa = addr_a[mem_aw-1:0];
	assign wb = addr_b[mem_aw-1:0];

	// both ports in one block, same-address collisions are undefined anyway
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[wa] <= data_a;
			q_a <= data_a;   // write returns new data
		end else begin
			q_a <= mem[wa];
		end
		if (we_b) begin
			mem[wb] <= data_b;
			q_b <= data_b;
		end else begin
			q_b <= mem[wb];
		end
	end

endmodule

// ==== rtl/cpu16_pkg.sv ====
package cpu16_pkg;

	// widths
	localparam int data_w = 16;   // data, address and instruction word
	localparam int op_w = 4;
	localparam int reg_aw = 4;
	localparam int num_regs = 16;
	localparam int flag_w = 5;

	// memory
	localparam int mem_depth = 256;
	localparam int mem_aw = 8;    // low address bits actually decoded

	// opcodes in ir[15:12]
	localparam logic [3:0] op_add = 4'd0;
	localparam logic [3:0] op_addi = 4'd1;   // sign-extended imm
	localparam logic [3:0] op_sub = 4'd2;
	localparam logic [3:0] op_subi = 4'd3;   // sign-extended imm
	localparam logic [3:0] op_and = 4'd4;
	localparam logic [3:0] op_or = 4'd5;
	localparam logic [3:0] op_xor = 4'd6;
	localparam logic [3:0] op_mov = 4'd7;
	localparam logic [3:0] op_movi = 4'd8;   // zero-extended imm
	localparam logic [3:0] op_cmp = 4'd9;
	localparam logic [3:0] op_addc = 4'd10;
	localparam logic [3:0] op_load = 4'd11;
	localparam logic [3:0] op_stor = 4'd12;
	localparam logic [3:0] op_bcond = 4'd13;
	localparam logic [3:0] op_jcond = 4'd14;
	localparam logic [3:0] op_nop = 4'd15;

	// condition codes in ir[11:8], anything not listed never holds
	localparam logic [3:0] cond_eq = 4'd0;   // z
	localparam logic [3:0] cond_ne = 4'd1;   // !z
	localparam logic [3:0] cond_cs = 4'd2;   // c
	localparam logic [3:0] cond_cc = 4'd3;   // !c
	localparam logic [3:0] cond_lo = 4'd4;   // l
	localparam logic [3:0] cond_hs = 4'd5;   // !l
	localparam logic [3:0] cond_mi = 4'd6;   // n
	localparam logic [3:0] cond_uc = 4'd14;  // always

	// flag bit positions
	localparam int flag_n = 4;
	localparam int flag_c = 3;   // carry, or borrow on subtract
	localparam int flag_f = 2;   // signed overflow
	localparam int flag_z = 1;
	localparam int flag_l = 0;   // unsigned less-than

	// pc next-value select
	localparam logic [1:0] pcsel_inc = 2'd0;
	localparam logic [1:0] pcsel_branch = 2'd1;
	localparam logic [1:0] pcsel_jump = 2'd2;

	// control fsm
	localparam logic [1:0] st_fetch = 2'd0;
	localparam logic [1:0] st_decode = 2'd1;
	localparam logic [1:0] st_exec = 2'd2;
	localparam logic [1:0] st_wb = 2'd3;   // load write-back only

endpackage
